//--- axi_freq_selector.f
src/freqsel_pkg.sv
src/ring_wr_if.sv
src/ring_rd_if.sv
src/axi_reg_frontend.sv
src/ring_store.sv
src/index_sequencer.sv
src/axi_freq_selector.sv
dv/freqsel_checker.sv
dv/tb_axi_freq_selector.sv

//--- Bender.yml
package:
  name: axi_freq_selector

sources:
  - src/freqsel_pkg.sv
  - src/ring_wr_if.sv
  - src/ring_rd_if.sv
  - src/axi_reg_frontend.sv
  - src/ring_store.sv
  - src/index_sequencer.sv
  - src/axi_freq_selector.sv
  - target: test
    files:
      - dv/freqsel_checker.sv
      - dv/tb_axi_freq_selector.sv

//--- dv/tb_axi_freq_selector.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_freq_selector;
    localparam int DEPTH        = 4;
    localparam int IDX_W        = $clog2(DEPTH);
    localparam int NAME_W       = 8 * 16;
    localparam int MAX_ROWS     = 48;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 5;

    localparam int OP_WRITE      = 0;
    localparam int OP_READ       = 1;
    localparam int OP_STEP       = 2;
    localparam int OP_LOOK       = 3;
    localparam int OP_WRITE_HELD = 4;
    localparam int OP_READ_HELD  = 5;

    localparam logic [3:0] A_ENTRY  = {freqsel_pkg::REG_ENTRY, 2'b00};
    localparam logic [3:0] A_CTRL   = {freqsel_pkg::REG_CTRL, 2'b00};
    localparam logic [3:0] A_COUNT  = {freqsel_pkg::REG_COUNT, 2'b00};
    localparam logic [3:0] A_STATUS = {freqsel_pkg::REG_STATUS, 2'b00};

    logic S_AXI_ACLK, S_AXI_ARESETN;
    logic [3:0] S_AXI_AWADDR, S_AXI_ARADDR;
    logic [2:0] S_AXI_AWPROT, S_AXI_ARPROT;
    logic S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic [31:0] S_AXI_WDATA, S_AXI_RDATA;
    logic [3:0] S_AXI_WSTRB;
    logic [1:0] S_AXI_BRESP, S_AXI_RRESP;
    logic S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic S_AXI_RVALID, S_AXI_RREADY;
    logic rd_en, last, en;
    logic [IDX_W-1:0] index;
    logic [13:0] k;

    logic row_done, write_hold, read_hold;
    logic [1:0] row_kind;
    logic [NAME_W-1:0] row_name;
    logic [31:0] row_exp, row_mask, pass_count, fail_count;

    // stimulus table
    logic [NAME_W-1:0] name_tab [MAX_ROWS];
    int                op_tab   [MAX_ROWS];
    logic [3:0]        addr_tab [MAX_ROWS];
    logic [31:0]       data_tab [MAX_ROWS];
    logic [31:0]       exp_tab  [MAX_ROWS];
    logic [31:0]       mask_tab [MAX_ROWS];
    int                n_rows;
    int                cycle_limit;
    int                cycles;

    // reference model of the table
    logic [13:0] model_mem [DEPTH];
    int          model_cnt;
    int          model_idx;
    logic [31:0] seed;

    axi_freq_selector #(.DEPTH(DEPTH)) u_axi_freq_selector (
        .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWPROT(S_AXI_AWPROT),
        .S_AXI_AWVALID(S_AXI_AWVALID), .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA(S_AXI_WDATA), .S_AXI_WSTRB(S_AXI_WSTRB),
        .S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
        .S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
        .S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARPROT(S_AXI_ARPROT),
        .S_AXI_ARVALID(S_AXI_ARVALID), .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA(S_AXI_RDATA), .S_AXI_RRESP(S_AXI_RRESP),
        .S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
        .rd_en(rd_en), .index(index), .k(k), .last(last), .en(en)
    );

    freqsel_checker #(.DEPTH(DEPTH), .NAME_W(NAME_W)) u_checker (
        .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .row_done(row_done), .row_kind(row_kind), .row_name(row_name),
        .row_exp(row_exp), .row_mask(row_mask),
        .write_hold(write_hold), .read_hold(read_hold),
        .awready(S_AXI_AWREADY), .wready(S_AXI_WREADY),
        .bvalid(S_AXI_BVALID), .bready(S_AXI_BREADY),
        .bresp(S_AXI_BRESP), .rvalid(S_AXI_RVALID), .rready(S_AXI_RREADY),
        .rdata(S_AXI_RDATA), .rresp(S_AXI_RRESP),
        .index(index), .k(k), .last(last), .en(en),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    always #20 S_AXI_ACLK = ~S_AXI_ACLK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // move the name to the top bytes so it prints without leading nulls
    function automatic logic [NAME_W-1:0] left_justify(input logic [NAME_W-1:0] s);
        logic [NAME_W-1:0] t;
        t = s;
        for (int i = 0; i < NAME_W / 8; i++) begin
            if (t[NAME_W-1 -: 8] == 8'h00) begin
                t = {t[NAME_W-9:0], 8'h20};
            end
        end
        return t;
    endfunction

    // packed {en, last, index, k} as the model sees it
    function automatic logic [31:0] datapath_expect();
        logic en_m;
        logic last_m;
        en_m   = (model_cnt != 0);
        last_m = en_m && (model_idx == model_cnt - 1);
        return 32'({en_m, last_m, IDX_W'(model_idx), model_mem[model_idx]});
    endfunction

    // k is unknown before the first entry is ever written
    function automatic logic [31:0] datapath_mask();
        return $isunknown(model_mem[model_idx]) ? ~32'h3fff : 32'hffff_ffff;
    endfunction

    function automatic logic [31:0] register_expect(input logic [3:0] addr);
        if (addr == A_COUNT) begin
            return 32'(model_cnt);
        end else if (addr == A_STATUS) begin
            return {30'd0, model_cnt != 0, model_cnt == DEPTH};
        end
        return 32'd0;
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input int op, input logic [3:0] addr,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic [31:0] mask);
        name_tab[n_rows] = left_justify(name);
        op_tab[n_rows]   = op;
        addr_tab[n_rows] = addr;
        data_tab[n_rows] = data;
        exp_tab[n_rows]  = exp;
        mask_tab[n_rows] = mask;
        n_rows++;
    endtask

    task automatic model_push(input logic [13:0] v);
        if (model_cnt < DEPTH) begin
            model_mem[model_cnt] = v;
            model_cnt++;
        end
    endtask

    task automatic push_entry(input logic [NAME_W-1:0] name);
        logic [13:0] v;
        seed = xorshift(seed);
        v    = seed[13:0];
        add_row(name, OP_WRITE, A_ENTRY, 32'(v), '0, '0);
        model_push(v);
    endtask

    task automatic read_row(input logic [NAME_W-1:0] name, input logic [3:0] addr);
        add_row(name, OP_READ, addr, '0, register_expect(addr), 32'hffff_ffff);
    endtask

    task automatic step_row(input logic [NAME_W-1:0] name);
        if (model_cnt != 0) begin
            model_idx = (model_idx == model_cnt - 1) ? 0 : model_idx + 1;
        end
        add_row(name, OP_STEP, '0, '0, datapath_expect(), datapath_mask());
    endtask

    task automatic look_row(input logic [NAME_W-1:0] name);
        add_row(name, OP_LOOK, '0, '0, datapath_expect(), datapath_mask());
    endtask

    task automatic build_table();
        logic [13:0] v1;
        logic [13:0] v2;
        n_rows    = 0;
        model_cnt = 0;
        model_idx = 0;
        seed      = 32'd39987;
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = 'x;
        end
        read_row("rst_count", A_COUNT);
        look_row("rst_look");
        push_entry("load_0");
        push_entry("load_1");
        push_entry("load_2");
        read_row("load_count", A_COUNT);
        read_row("load_status", A_STATUS);
        look_row("load_look");
        for (int i = 0; i < 4; i++) begin
            step_row("step_circ");
        end
        push_entry("ovf_push3");
        // table is full now, so this entry is dropped
        push_entry("ovf_push4");
        read_row("ovf_count", A_COUNT);
        read_row("ovf_status", A_STATUS);
        for (int i = 0; i < 4; i++) begin
            step_row("ovf_step");
        end
        add_row("clr_write", OP_WRITE, A_CTRL, 32'd1, '0, '0);
        model_cnt = 0;
        model_idx = 0;
        read_row("clr_count", A_COUNT);
        look_row("clr_look");
        step_row("clr_step_empty");
        push_entry("clr_push");
        look_row("clr_new_look");
        // two entries packed into one row, low half first
        seed = xorshift(seed);
        v1   = seed[13:0];
        seed = xorshift(seed);
        v2   = seed[13:0];
        add_row("bp_write", OP_WRITE_HELD, A_ENTRY, {2'b00, v2, 2'b00, v1}, '0, '0);
        model_push(v1);
        model_push(v2);
        add_row("bp_read", OP_READ_HELD, A_COUNT, '0, register_expect(A_COUNT), 32'hffff_ffff);
        step_row("bp_step");
    endtask

    task automatic send_aw_w(input logic [3:0] addr, input logic [31:0] data);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        do @(posedge S_AXI_ACLK); while (!S_AXI_AWREADY);
        #1;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
    endtask

    task automatic take_b();
        do @(posedge S_AXI_ACLK); while (!(S_AXI_BVALID && S_AXI_BREADY));
        #1;
    endtask

    task automatic write_held(input logic [31:0] data);
        S_AXI_BREADY = 1'b0;
        send_aw_w(A_ENTRY, 32'(data[13:0]));
        do @(posedge S_AXI_ACLK); while (!S_AXI_BVALID);
        #1;
        // second write waits behind the pending response
        S_AXI_AWADDR  = A_ENTRY;
        S_AXI_WDATA   = 32'(data[29:16]);
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        write_hold    = 1'b1;
        repeat (HOLD_CYCLES) @(posedge S_AXI_ACLK);
        #1;
        write_hold   = 1'b0;
        S_AXI_BREADY = 1'b1;
        take_b();
        do @(posedge S_AXI_ACLK); while (!S_AXI_AWREADY);
        #1;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        take_b();
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        S_AXI_RREADY  = (hold == 0);
        do @(posedge S_AXI_ACLK); while (!S_AXI_ARREADY);
        #1;
        S_AXI_ARVALID = 1'b0;
        if (hold != 0) begin
            do @(posedge S_AXI_ACLK); while (!S_AXI_RVALID);
            #1;
            read_hold = 1'b1;
            repeat (hold) @(posedge S_AXI_ACLK);
            #1;
            read_hold    = 1'b0;
            S_AXI_RREADY = 1'b1;
        end
        do @(posedge S_AXI_ACLK); while (!(S_AXI_RVALID && S_AXI_RREADY));
        #1;
    endtask

    initial begin : watchdog
        cycles = 0;
        @(posedge S_AXI_ACLK);
        while (cycles < cycle_limit) begin
            @(posedge S_AXI_ACLK);
            cycles++;
        end
        $display("timeout: the DUT did not respond within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin : driver
        int op;
        S_AXI_ACLK = 1'b0;
        S_AXI_ARESETN = 1'b0;
        {S_AXI_AWADDR, S_AXI_ARADDR, S_AXI_AWPROT, S_AXI_ARPROT} = '0;
        {S_AXI_AWVALID, S_AXI_WVALID, S_AXI_ARVALID, rd_en} = '0;
        S_AXI_WDATA  = '0;
        S_AXI_WSTRB  = 4'hf;
        S_AXI_BREADY = 1'b1;
        S_AXI_RREADY = 1'b1;
        {row_done, write_hold, read_hold, row_kind} = '0;
        row_name = '0;
        row_exp  = '0;
        row_mask = '0;
        build_table();
        cycle_limit = 40 * n_rows + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            op       = op_tab[r];
            row_name = name_tab[r];
            row_exp  = exp_tab[r];
            row_mask = mask_tab[r];
            row_kind = (op == OP_READ || op == OP_READ_HELD) ? 2'd1 :
                       (op == OP_STEP || op == OP_LOOK) ? 2'd2 : 2'd0;
            case (op)
                OP_WRITE: begin
                    send_aw_w(addr_tab[r], data_tab[r]);
                    take_b();
                end
                OP_READ:       axi_read(addr_tab[r], 0);
                OP_READ_HELD:  axi_read(addr_tab[r], HOLD_CYCLES);
                OP_WRITE_HELD: write_held(data_tab[r]);
                OP_STEP: begin
                    rd_en = 1'b1;
                    @(posedge S_AXI_ACLK);
                    #1;
                    rd_en = 1'b0;
                end
                default: ;
            endcase
            row_done = 1'b1;
            @(posedge S_AXI_ACLK);
            #1;
            row_done = 1'b0;
        end
        $display("rows %0d, passed %0d, failed %0d", n_rows, pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_rows) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/freqsel_checker.sv
`timescale 1ns/1ps
`default_nettype none

module freqsel_checker #(
    parameter int DEPTH  = 4,
    parameter int NAME_W = 128
) (
    input  wire                          S_AXI_ACLK,
    input  wire                          S_AXI_ARESETN,
    // row strobe and expected values from the driver
    input  wire                          row_done,
    input  wire  [1:0]                   row_kind,
    input  wire  [NAME_W-1:0]            row_name,
    input  wire  [31:0]                  row_exp,
    input  wire  [31:0]                  row_mask,
    input  wire                          write_hold,
    input  wire                          read_hold,
    // DUT outputs
    input  wire                          awready,
    input  wire                          wready,
    input  wire                          bvalid,
    input  wire                          bready,
    input  wire  [1:0]                   bresp,
    input  wire                          rvalid,
    input  wire                          rready,
    input  wire  [31:0]                  rdata,
    input  wire  [1:0]                   rresp,
    input  wire  [$clog2(DEPTH)-1:0]     index,
    input  wire  [13:0]                  k,
    input  wire                          last,
    input  wire                          en,
    output logic [31:0]                  pass_count,
    output logic [31:0]                  fail_count
);
    logic [31:0] rd_cap;
    logic [31:0] actual;
    logic        row_bad;

    // kind 1 is a register read, kind 2 the datapath outputs
    always_comb begin
        case (row_kind)
            2'd1:    actual = rd_cap;
            2'd2:    actual = 32'({en, last, index, k});
            default: actual = row_exp;
        endcase
    end

    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            pass_count <= '0;
            fail_count <= '0;
            row_bad    <= 1'b0;
        end else begin
            // address and data ready pulse on the same edge
            if (wready != awready) begin
                $display("awready and wready did not rise together in test %s", row_name);
                row_bad <= 1'b1;
            end
            if (bvalid && bready && bresp != freqsel_pkg::RESP_OKAY) begin
                $display("write response was not OKAY in test %s", row_name);
                row_bad <= 1'b1;
            end
            if (rvalid && rready) begin
                rd_cap <= rdata;
                if (rresp != freqsel_pkg::RESP_OKAY) begin
                    $display("read response was not OKAY in test %s", row_name);
                    row_bad <= 1'b1;
                end
            end
            // response must sit still while the master holds ready low
            if (write_hold && (!bvalid || awready)) begin
                $display("CHECK FAILED: expected bvalid/awready 1/0, actual %0d/%0d, test %s",
                         bvalid, awready, row_name);
                row_bad <= 1'b1;
            end
            if (read_hold && (!rvalid || rdata != row_exp)) begin
                $display("CHECK FAILED: expected rdata 0x%0h, actual 0x%0h rvalid %0d, test %s",
                         row_exp, rdata, rvalid, row_name);
                row_bad <= 1'b1;
            end
            if (row_done) begin
                if ((actual & row_mask) != (row_exp & row_mask)) begin
                    $display("CHECK FAILED: expected 0x%0h, actual 0x%0h, test %s",
                             row_exp & row_mask, actual & row_mask, row_name);
                    fail_count <= fail_count + 1;
                end else if (row_bad) begin
                    $display("failed on an earlier error: test %s", row_name);
                    fail_count <= fail_count + 1;
                end else begin
                    $display("passed: test %s", row_name);
                    pass_count <= pass_count + 1;
                end
                row_bad <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/axi_freq_selector.sv
`timescale 1ns/1ps
`default_nettype none

module axi_freq_selector #(
    parameter int DEPTH = 16
) (
    input  wire                                      S_AXI_ACLK,
    input  wire                                      S_AXI_ARESETN,
    input  wire  [freqsel_pkg::ADDR_WIDTH-1:0]       S_AXI_AWADDR,
    input  wire  [2:0]                               S_AXI_AWPROT,
    input  wire                                      S_AXI_AWVALID,
    output logic                                     S_AXI_AWREADY,
    input  wire  [freqsel_pkg::DATA_WIDTH-1:0]       S_AXI_WDATA,
    input  wire  [freqsel_pkg::DATA_WIDTH/8-1:0]     S_AXI_WSTRB,
    input  wire                                      S_AXI_WVALID,
    output logic                                     S_AXI_WREADY,
    output logic [1:0]                               S_AXI_BRESP,
    output logic                                     S_AXI_BVALID,
    input  wire                                      S_AXI_BREADY,
    input  wire  [freqsel_pkg::ADDR_WIDTH-1:0]       S_AXI_ARADDR,
    input  wire  [2:0]                               S_AXI_ARPROT,
    input  wire                                      S_AXI_ARVALID,
    output logic                                     S_AXI_ARREADY,
    output logic [freqsel_pkg::DATA_WIDTH-1:0]       S_AXI_RDATA,
    output logic [1:0]                               S_AXI_RRESP,
    output logic                                     S_AXI_RVALID,
    input  wire                                      S_AXI_RREADY,
    // datapath side
    input  wire                                      rd_en,
    output logic [$clog2(DEPTH)-1:0]                 index,
    output freqsel_pkg::k_t                          k,
    output logic                                     last,
    output logic                                     en
);
    ring_wr_if #(.DEPTH(DEPTH)) wr_bus ();
    ring_rd_if #(.DEPTH(DEPTH)) rd_bus ();

    axi_reg_frontend #(.DEPTH(DEPTH)) u_frontend (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awaddr        (S_AXI_AWADDR),
        .awprot        (S_AXI_AWPROT),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .araddr        (S_AXI_ARADDR),
        .arprot        (S_AXI_ARPROT),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rdata         (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .wr            (wr_bus.producer)
    );

    ring_store #(.DEPTH(DEPTH)) u_store (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr            (wr_bus.buffer),
        .rd            (rd_bus.buffer)
    );

    index_sequencer #(.DEPTH(DEPTH)) u_sequencer (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .rd_en         (rd_en),
        .index         (index),
        .k             (k),
        .last          (last),
        .en            (en),
        .rd            (rd_bus.consumer)
    );

endmodule

`default_nettype wire

//--- src/index_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module index_sequencer #(
    parameter int DEPTH = 16
) (
    input  wire                        S_AXI_ACLK,
    input  wire                        S_AXI_ARESETN,
    input  wire                        rd_en,
    output logic [$clog2(DEPTH)-1:0]   index,
    output freqsel_pkg::k_t            k,
    output logic                       last,
    output logic                       en,
    ring_rd_if.consumer                rd
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [IDX_W-1:0] idx;

    assign en   = (rd.count != '0);
    assign last = en && (CNT_W'(idx) == rd.count - CNT_W'(1));

    // wrap at the live count so new entries join the loop
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || rd.clear_seen) begin
            idx <= '0;
        end else if (rd_en && en) begin
            if (last) begin
                idx <= '0;
            end else begin
                idx <= idx + IDX_W'(1);
            end
        end
    end

    assign rd.rd_index = idx;
    assign index       = idx;
    assign k           = rd.rd_data;

    a_idx_in_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        en |-> CNT_W'(idx) < rd.count);

endmodule

`default_nettype wire

//--- src/ring_store.sv
`timescale 1ns/1ps
`default_nettype none

module ring_store #(
    parameter int DEPTH = 16
) (
    input  wire      S_AXI_ACLK,
    input  wire      S_AXI_ARESETN,
    ring_wr_if.buffer wr,
    ring_rd_if.buffer rd
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    freqsel_pkg::k_t   mem [DEPTH];
    logic [IDX_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_push;

    assign full    = (count == CNT_W'(DEPTH));
    // clear wins over a push in the same cycle
    assign do_push = wr.push && !full && !wr.clear;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || wr.clear) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + IDX_W'(1);
            count  <= count + CNT_W'(1);
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.wdata;
        end
    end

    assign wr.count = count;
    assign wr.full  = full;

    // asynchronous read port
    assign rd.rd_data    = mem[rd.rd_index];
    assign rd.count      = count;
    assign rd.clear_seen = wr.clear;

    a_count_bound: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        count <= CNT_W'(DEPTH));

    a_push_full: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr.push && full && !wr.clear |=> count == $past(count));

endmodule

`default_nettype wire

//--- src/axi_reg_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_frontend #(
    parameter int DEPTH = 16
) (
    input  wire                                      S_AXI_ACLK,
    input  wire                                      S_AXI_ARESETN,
    input  wire  [freqsel_pkg::ADDR_WIDTH-1:0]       awaddr,
    input  wire  [2:0]                               awprot,
    input  wire                                      awvalid,
    output logic                                     awready,
    input  wire  [freqsel_pkg::DATA_WIDTH-1:0]       wdata,
    input  wire  [freqsel_pkg::DATA_WIDTH/8-1:0]     wstrb,
    input  wire                                      wvalid,
    output logic                                     wready,
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  wire                                      bready,
    input  wire  [freqsel_pkg::ADDR_WIDTH-1:0]       araddr,
    input  wire  [2:0]                               arprot,
    input  wire                                      arvalid,
    output logic                                     arready,
    output logic [freqsel_pkg::DATA_WIDTH-1:0]       rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  wire                                      rready,
    ring_wr_if.producer                              wr
);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic                                 aw_en;
    logic                                 aw_accept;
    logic                                 wren;
    logic                                 rden;
    freqsel_pkg::reg_addr_e               aw_sel;
    freqsel_pkg::reg_addr_e               ar_sel;
    logic [CNT_W-1:0]                     cur_count;
    logic [freqsel_pkg::DATA_WIDTH-1:0]   rd_mux;

    assign bresp = freqsel_pkg::RESP_OKAY;
    assign rresp = freqsel_pkg::RESP_OKAY;

    // address and data taken together, one outstanding response at a time
    assign aw_accept = ~awready && awvalid && wvalid && aw_en;
    assign wren      = awready && awvalid && wready && wvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_en   <= 1'b1;
        end else begin
            awready <= aw_accept;
            wready  <= aw_accept;
            if (aw_accept) begin
                aw_en <= 1'b0;
            end else if (bready && bvalid) begin
                aw_en <= 1'b1;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_accept) begin
            aw_sel <= freqsel_pkg::reg_addr_e'(awaddr[3:2]);
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            bvalid <= 1'b0;
        end else if (wren && !bvalid) begin
            bvalid <= 1'b1;
        end else if (bready && bvalid) begin
            bvalid <= 1'b0;
        end
    end

    // strobes land in the store on the edge that raises bvalid
    assign wr.push  = wren && (aw_sel == freqsel_pkg::REG_ENTRY) && (wstrb[1:0] == 2'b11);
    assign wr.wdata = wdata[freqsel_pkg::K_WIDTH-1:0];
    assign wr.clear = wren && (aw_sel == freqsel_pkg::REG_CTRL) && wstrb[0] && wdata[0];

    // read address
    assign rden = arready && arvalid && !rvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            arready <= 1'b0;
        end else begin
            arready <= ~arready && arvalid && !rvalid;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (~arready && arvalid && !rvalid) begin
            ar_sel <= freqsel_pkg::reg_addr_e'(araddr[3:2]);
        end
    end

    assign cur_count = wr.count;

    always_comb begin
        rd_mux = '0;
        case (ar_sel)
            freqsel_pkg::REG_COUNT: begin
                rd_mux = freqsel_pkg::DATA_WIDTH'(cur_count);
            end
            freqsel_pkg::REG_STATUS: begin
                rd_mux[freqsel_pkg::STATUS_FULL_BIT]      = wr.full;
                rd_mux[freqsel_pkg::STATUS_NOT_EMPTY_BIT] = (cur_count != '0);
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rvalid <= 1'b0;
        end else if (rden) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (rden) begin
            rdata <= rd_mux;
        end
    end

    // responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata));

    a_aw_known: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        awvalid |-> !$isunknown({awaddr, awprot}));

    a_ar_known: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        arvalid |-> !$isunknown({araddr, arprot}));

endmodule

`default_nettype wire

//--- src/ring_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ring_rd_if #(
    parameter int DEPTH = 16
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [IDX_W-1:0]  rd_index;
    freqsel_pkg::k_t   rd_data;
    logic [CNT_W-1:0]  count;
    // clear strobe passed through from the write side
    logic              clear_seen;

    modport buffer (input rd_index, output rd_data, output count, output clear_seen);

    modport consumer (output rd_index, input rd_data, input count, input clear_seen);

endinterface

`default_nettype wire

//--- src/ring_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ring_wr_if #(
    parameter int DEPTH = 16
);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // push and clear are single-cycle strobes
    logic              push;
    freqsel_pkg::k_t   wdata;
    logic              clear;
    logic [CNT_W-1:0]  count;
    logic              full;

    modport producer (output push, output wdata, output clear, input count, input full);

    modport buffer (input push, input wdata, input clear, output count, output full);

endinterface

`default_nettype wire

//--- src/freqsel_pkg.sv
`default_nettype none

package freqsel_pkg;

    // AXI4-Lite bus widths
    localparam int ADDR_WIDTH = 4;
    localparam int DATA_WIDTH = 32;

    // one frequency selector word
    localparam int K_WIDTH = 14;

    typedef logic [K_WIDTH-1:0] k_t;

    // word index taken from address bits 3:2
    typedef enum logic [1:0] {
        REG_ENTRY  = 2'd0,
        REG_CTRL   = 2'd1,
        REG_COUNT  = 2'd2,
        REG_STATUS = 2'd3
    } reg_addr_e;

    // status word bit positions
    localparam int STATUS_FULL_BIT     = 0;
    localparam int STATUS_NOT_EMPTY_BIT = 1;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
